/* verilog/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Widths fixed by the ISA subset

`define NB_DATA     32  // Data word and instruction width

`define NB_REG      5  // Register index, 32 architectural registers

`define NB_PC       8  // Byte address of the instruction, wraps at 256

`define NB_ALU_OP   3  // Class handed from decode to execute

`define NB_ALU_CTRL 4  // Operation select of the ALU

`endif

/* verilog/mips_pkg.sv */
`include "mips_macros.svh"

package mips_pkg;

    typedef logic [`NB_DATA-1:0] data_t;
    typedef logic [`NB_REG-1:0]  reg_idx_t;
    typedef logic [`NB_PC-1:0]   pc_t;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_SW    = 6'h2b
    } opcode_e;

    // Function field of R-type, instr[5:0]
    typedef enum logic [5:0] {
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_SLT = 6'h2a
    } funct_e;

    typedef enum logic [`NB_ALU_OP-1:0] {
        ALUOP_ADD   = 3'b000,
        ALUOP_SUB   = 3'b001,
        ALUOP_FUNCT = 3'b010,  // Operation comes from the funct field
        ALUOP_AND   = 3'b011,
        ALUOP_OR    = 3'b100,
        ALUOP_SLT   = 3'b101
    } alu_op_e;

    typedef enum logic [`NB_ALU_CTRL-1:0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_SUB = 4'b0110,
        ALU_SLT = 4'b0111
    } alu_ctrl_e;

endpackage

/* verilog/alu.sv */
module alu (
    input  mips_pkg::data_t     i_a,
    input  mips_pkg::data_t     i_b,
    input  mips_pkg::alu_ctrl_e i_alu_ctrl,
    output mips_pkg::data_t     o_result,
    output logic                o_zero
);
    import mips_pkg::*;

    logic less;

    assign less = $signed(i_a) < $signed(i_b);

    always_comb begin
        case (i_alu_ctrl)
            ALU_AND: begin
                o_result = i_a & i_b;
            end
            ALU_OR: begin
                o_result = i_a | i_b;
            end
            ALU_ADD: begin
                o_result = i_a + i_b;  // Wraps, no overflow trap
            end
            ALU_SUB: begin
                o_result = i_a - i_b;
            end
            ALU_SLT: begin
                o_result = data_t'(less);
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

/* verilog/main_control.sv */
module main_control (
    input  logic               i_clock,
    input  logic               i_rst,
    input  logic               i_valid,
    input  mips_pkg::data_t    i_instr,
    input  mips_pkg::pc_t      i_pc,
    output logic               o_valid,
    output logic               o_reg_write,
    output logic               o_mem_write,
    output logic               o_branch,
    output logic               o_alu_src,
    output logic               o_reg_dst,
    output mips_pkg::alu_op_e  o_alu_op,
    output mips_pkg::data_t    o_immediate,
    output mips_pkg::reg_idx_t o_rs,
    output mips_pkg::reg_idx_t o_rt,
    output mips_pkg::reg_idx_t o_rd,
    output mips_pkg::pc_t      o_pc
);
    import mips_pkg::*;

    opcode_e  opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    data_t    immediate;
    logic     dec_reg_write;
    logic     dec_mem_write;
    logic     dec_branch;
    logic     dec_alu_src;
    logic     dec_reg_dst;
    logic     dec_zero_ext;
    alu_op_e  dec_alu_op;
    logic     dest_nonzero;

    assign opcode = opcode_e'(i_instr[31:26]);
    assign rs     = i_instr[25:21];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];

    // Logical immediates are zero extended, arithmetic and offsets sign extended
    assign immediate = dec_zero_ext ? {16'h0000, i_instr[15:0]}
                                    : {{16{i_instr[15]}}, i_instr[15:0]};

    always_comb begin
        dec_reg_write = 1'b0;
        dec_mem_write = 1'b0;
        dec_branch    = 1'b0;
        dec_alu_src   = 1'b0;
        dec_reg_dst   = 1'b0;
        dec_zero_ext  = 1'b0;
        dec_alu_op    = ALUOP_ADD;
        case (opcode)
            OP_RTYPE: begin
                dec_reg_write = 1'b1;
                dec_reg_dst   = 1'b1;
                dec_alu_op    = ALUOP_FUNCT;
            end
            OP_ADDI: begin
                dec_reg_write = 1'b1;
                dec_alu_src   = 1'b1;
            end
            OP_SLTI: begin
                dec_reg_write = 1'b1;
                dec_alu_src   = 1'b1;
                dec_alu_op    = ALUOP_SLT;
            end
            OP_ANDI: begin
                dec_reg_write = 1'b1;
                dec_alu_src   = 1'b1;
                dec_zero_ext  = 1'b1;
                dec_alu_op    = ALUOP_AND;
            end
            OP_ORI: begin
                dec_reg_write = 1'b1;
                dec_alu_src   = 1'b1;
                dec_zero_ext  = 1'b1;
                dec_alu_op    = ALUOP_OR;
            end
            OP_BEQ: begin
                dec_branch = 1'b1;
                dec_alu_op = ALUOP_SUB;  // Equality through a zero difference
            end
            OP_SW: begin
                dec_mem_write = 1'b1;
                dec_alu_src   = 1'b1;  // Address is base plus offset
            end
            default: begin
                dec_alu_op = ALUOP_ADD;  // Retires as a no-op
            end
        endcase
    end

    assign dest_nonzero = dec_reg_dst ? (rd != '0) : (rt != '0);

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_valid     <= 1'b0;
            o_reg_write <= 1'b0;
            o_mem_write <= 1'b0;
            o_branch    <= 1'b0;
        end else begin
            o_valid     <= i_valid;
            o_reg_write <= i_valid & dec_reg_write & dest_nonzero;  // r0 is never a target
            o_mem_write <= i_valid & dec_mem_write;
            o_branch    <= i_valid & dec_branch;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_valid) begin
            o_alu_src   <= dec_alu_src;
            o_reg_dst   <= dec_reg_dst;
            o_alu_op    <= dec_alu_op;
            o_immediate <= immediate;
            o_rs        <= rs;
            o_rt        <= rt;
            o_rd        <= rd;
            o_pc        <= i_pc;
        end
    end

    a_write_excl: assert property (@(posedge i_clock) disable iff (i_rst)
        !(o_reg_write && o_mem_write));

endmodule

/* verilog/register_file.sv */
`include "mips_macros.svh"

module register_file (
    input  logic               i_clock,
    input  logic               i_rst,
    input  logic               i_rd_en,
    input  mips_pkg::reg_idx_t i_rs,
    input  mips_pkg::reg_idx_t i_rt,
    input  logic               i_wr_en,
    input  mips_pkg::reg_idx_t i_wr_reg,
    input  mips_pkg::data_t    i_wr_data,
    output mips_pkg::data_t    o_data_a,
    output mips_pkg::data_t    o_data_b
);
    import mips_pkg::*;

    data_t regs [2**`NB_REG];
    logic  wr_live;
    data_t rd_data_a;
    data_t rd_data_b;

    assign wr_live = i_wr_en && (i_wr_reg != '0);

    // A write on the read edge is returned directly
    assign rd_data_a = (wr_live && i_wr_reg == i_rs) ? i_wr_data : regs[i_rs];
    assign rd_data_b = (wr_live && i_wr_reg == i_rt) ? i_wr_data : regs[i_rt];

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < 2**`NB_REG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[i_wr_reg] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rd_en) begin
            o_data_a <= rd_data_a;
            o_data_b <= rd_data_b;
        end
    end

    // Decode already drops r0 destinations before they reach write-back
    a_no_r0_write: assert property (@(posedge i_clock) disable iff (i_rst)
        i_wr_en |-> (i_wr_reg != '0));

endmodule

/* verilog/ex_stage.sv */
module ex_stage (
    input  logic               i_clock,
    input  logic               i_rst,
    input  logic               i_valid,
    input  logic               i_reg_write,
    input  logic               i_mem_write,
    input  logic               i_branch,
    input  logic               i_alu_src,
    input  logic               i_reg_dst,
    input  mips_pkg::alu_op_e  i_alu_op,
    input  mips_pkg::pc_t      i_pc,
    input  mips_pkg::data_t    i_data_a,
    input  mips_pkg::data_t    i_data_b,
    input  mips_pkg::data_t    i_immediate,
    input  mips_pkg::reg_idx_t i_rs,
    input  mips_pkg::reg_idx_t i_rt,
    input  mips_pkg::reg_idx_t i_rd,
    output logic               o_valid,
    output logic               o_reg_write,
    output logic               o_mem_write,
    output logic               o_branch_taken,
    output mips_pkg::reg_idx_t o_dest_reg,
    output mips_pkg::data_t    o_alu_result,
    output mips_pkg::data_t    o_store_data,
    output mips_pkg::pc_t      o_branch_target
);
    import mips_pkg::*;

    funct_e    funct;
    alu_ctrl_e alu_ctrl;
    logic      funct_ok;
    data_t     operand_a;
    data_t     rt_value;
    data_t     operand_b;
    data_t     alu_result;
    logic      alu_zero;
    reg_idx_t  dest_reg;
    pc_t       pc_plus4;
    pc_t       branch_target;

    assign funct = funct_e'(i_immediate[5:0]);

    always_comb begin
        funct_ok = 1'b1;
        case (i_alu_op)
            ALUOP_SUB: alu_ctrl = ALU_SUB;
            ALUOP_AND: alu_ctrl = ALU_AND;
            ALUOP_OR:  alu_ctrl = ALU_OR;
            ALUOP_SLT: alu_ctrl = ALU_SLT;
            ALUOP_FUNCT: begin
                case (funct)
                    F_ADD:   alu_ctrl = ALU_ADD;
                    F_SUB:   alu_ctrl = ALU_SUB;
                    F_AND:   alu_ctrl = ALU_AND;
                    F_OR:    alu_ctrl = ALU_OR;
                    F_SLT:   alu_ctrl = ALU_SLT;
                    default: begin
                        alu_ctrl = ALU_ADD;
                        funct_ok = 1'b0;  // Unsupported R-type retires as a no-op
                    end
                endcase
            end
            default: alu_ctrl = ALU_ADD;
        endcase
    end

    // The EX/MEM register holds the producer issued one cycle earlier
    assign operand_a = (o_reg_write && o_dest_reg == i_rs) ? o_alu_result : i_data_a;
    assign rt_value  = (o_reg_write && o_dest_reg == i_rt) ? o_alu_result : i_data_b;
    assign operand_b = i_alu_src ? i_immediate : rt_value;
    assign dest_reg  = i_reg_dst ? i_rd : i_rt;

    alu i_alu (
        .i_a        (operand_a),
        .i_b        (operand_b),
        .i_alu_ctrl (alu_ctrl),
        .o_result   (alu_result),
        .o_zero     (alu_zero)
    );

    assign pc_plus4      = i_pc + pc_t'(4);
    assign branch_target = pc_plus4 + pc_t'(i_immediate << 2);  // Wraps at the PC width

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_valid        <= 1'b0;
            o_reg_write    <= 1'b0;
            o_mem_write    <= 1'b0;
            o_branch_taken <= 1'b0;
        end else begin
            o_valid        <= i_valid;
            o_reg_write    <= i_valid & i_reg_write & funct_ok;
            o_mem_write    <= i_valid & i_mem_write;
            o_branch_taken <= i_valid & i_branch & alu_zero;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_valid) begin
            o_dest_reg      <= dest_reg;
            o_alu_result    <= alu_result;
            o_store_data    <= rt_value;
            o_branch_target <= branch_target;
        end
    end

    a_bad_funct_no_write: assert property (@(posedge i_clock) disable iff (i_rst)
        (i_valid && i_alu_op == ALUOP_FUNCT
         && !(i_immediate[5:0] inside {F_ADD, F_SUB, F_AND, F_OR, F_SLT}))
        |=> !o_reg_write);

endmodule

/* verilog/mips_exec_top.sv */
module mips_exec_top (
    input  logic               i_clock,
    input  logic               i_rst,
    input  logic               i_valid,
    input  mips_pkg::data_t    i_instr,
    input  mips_pkg::pc_t      i_pc,
    output logic               o_valid,
    output logic               o_reg_write,
    output logic               o_mem_write,
    output logic               o_branch_taken,
    output mips_pkg::reg_idx_t o_dest_reg,
    output mips_pkg::data_t    o_alu_result,
    output mips_pkg::data_t    o_store_data,
    output mips_pkg::pc_t      o_branch_target
);
    import mips_pkg::*;

    logic     id_valid;
    logic     id_reg_write;
    logic     id_mem_write;
    logic     id_branch;
    logic     id_alu_src;
    logic     id_reg_dst;
    alu_op_e  id_alu_op;
    data_t    id_immediate;
    reg_idx_t id_rs;
    reg_idx_t id_rt;
    reg_idx_t id_rd;
    pc_t      id_pc;
    data_t    id_data_a;
    data_t    id_data_b;

    main_control i_main_control (
        .i_clock     (i_clock),
        .i_rst       (i_rst),
        .i_valid     (i_valid),
        .i_instr     (i_instr),
        .i_pc        (i_pc),
        .o_valid     (id_valid),
        .o_reg_write (id_reg_write),
        .o_mem_write (id_mem_write),
        .o_branch    (id_branch),
        .o_alu_src   (id_alu_src),
        .o_reg_dst   (id_reg_dst),
        .o_alu_op    (id_alu_op),
        .o_immediate (id_immediate),
        .o_rs        (id_rs),
        .o_rt        (id_rt),
        .o_rd        (id_rd),
        .o_pc        (id_pc)
    );

    // Write-back comes straight from the EX/MEM register
    register_file i_register_file (
        .i_clock   (i_clock),
        .i_rst     (i_rst),
        .i_rd_en   (i_valid),
        .i_rs      (i_instr[25:21]),
        .i_rt      (i_instr[20:16]),
        .i_wr_en   (o_reg_write),
        .i_wr_reg  (o_dest_reg),
        .i_wr_data (o_alu_result),
        .o_data_a  (id_data_a),
        .o_data_b  (id_data_b)
    );

    ex_stage i_ex_stage (
        .i_clock         (i_clock),
        .i_rst           (i_rst),
        .i_valid         (id_valid),
        .i_reg_write     (id_reg_write),
        .i_mem_write     (id_mem_write),
        .i_branch        (id_branch),
        .i_alu_src       (id_alu_src),
        .i_reg_dst       (id_reg_dst),
        .i_alu_op        (id_alu_op),
        .i_pc            (id_pc),
        .i_data_a        (id_data_a),
        .i_data_b        (id_data_b),
        .i_immediate     (id_immediate),
        .i_rs            (id_rs),
        .i_rt            (id_rt),
        .i_rd            (id_rd),
        .o_valid         (o_valid),
        .o_reg_write     (o_reg_write),
        .o_mem_write     (o_mem_write),
        .o_branch_taken  (o_branch_taken),
        .o_dest_reg      (o_dest_reg),
        .o_alu_result    (o_alu_result),
        .o_store_data    (o_store_data),
        .o_branch_target (o_branch_target)
    );

endmodule

/* tb/tb_mips_model.svh */
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

typedef struct packed {
    int       cycle;
    int       seq;
    opcode_e  opcode;
    logic     reg_write;
    logic     mem_write;
    logic     branch_taken;
    reg_idx_t dest_reg;
    data_t    alu_result;
    data_t    store_data;
    pc_t      branch_target;
} expect_t;

data_t       model_regs [32];
logic [31:0] rng_state;

function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic int unsigned rand_range(int unsigned n);
    return next_rand() % n;
endfunction

task automatic model_reset();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
endtask

// Runs one instruction in program order against the architectural registers
function automatic expect_t model_execute(data_t instr, pc_t pc);
    expect_t  exp;
    reg_idx_t rs;
    reg_idx_t rt;
    data_t    a;
    data_t    b;
    data_t    sext;
    data_t    zext;
    logic     writes;
    exp    = '0;
    rs     = instr[25:21];
    rt     = instr[20:16];
    a      = model_regs[rs];
    b      = model_regs[rt];
    sext   = {{16{instr[15]}}, instr[15:0]};
    zext   = {16'h0000, instr[15:0]};
    writes = 1'b1;
    exp.opcode   = opcode_e'(instr[31:26]);
    exp.dest_reg = rt;
    case (exp.opcode)
        OP_RTYPE: begin
            exp.dest_reg = instr[15:11];
            case (funct_e'(instr[5:0]))
                F_ADD:   exp.alu_result = a + b;
                F_SUB:   exp.alu_result = a - b;
                F_AND:   exp.alu_result = a & b;
                F_OR:    exp.alu_result = a | b;
                F_SLT:   exp.alu_result = data_t'($signed(a) < $signed(b));
                default: writes = 1'b0;
            endcase
        end
        OP_ADDI: exp.alu_result = a + sext;
        OP_SLTI: exp.alu_result = data_t'($signed(a) < $signed(sext));
        OP_ANDI: exp.alu_result = a & zext;
        OP_ORI:  exp.alu_result = a | zext;
        OP_BEQ: begin
            writes             = 1'b0;
            exp.branch_taken   = (a == b);
            exp.branch_target  = pc + 8'd4 + pc_t'(sext << 2);
        end
        OP_SW: begin
            writes         = 1'b0;
            exp.mem_write  = 1'b1;
            exp.alu_result = a + sext;  // Store address
            exp.store_data = b;
        end
        default: writes = 1'b0;
    endcase
    exp.reg_write = writes && (exp.dest_reg != '0);
    if (exp.reg_write) begin
        model_regs[exp.dest_reg] = exp.alu_result;
    end
    return exp;
endfunction

`endif

/* tb/tb_mips_exec.sv */
module tb_mips_exec;
    import mips_pkg::*;

    `include "tb_mips_model.svh"

    localparam int          num_instr  = 2000;
    localparam int          clk_period = 40;
    localparam logic [31:0] seed       = 32'd29541;
    localparam int          time_limit = (num_instr * 3 + 100) * clk_period;

    logic     i_clock;
    logic     i_rst;
    logic     i_valid;
    data_t    i_instr;
    pc_t      i_pc;
    logic     o_valid;
    logic     o_reg_write;
    logic     o_mem_write;
    logic     o_branch_taken;
    reg_idx_t o_dest_reg;
    data_t    o_alu_result;
    data_t    o_store_data;
    pc_t      o_branch_target;

    expect_t  exp_q [$];
    int       cycle_count = 0;
    int       check_seq = 0;

    mips_exec_top i_mips_exec_top (
        .i_clock         (i_clock),
        .i_rst           (i_rst),
        .i_valid         (i_valid),
        .i_instr         (i_instr),
        .i_pc            (i_pc),
        .o_valid         (o_valid),
        .o_reg_write     (o_reg_write),
        .o_mem_write     (o_mem_write),
        .o_branch_taken  (o_branch_taken),
        .o_dest_reg      (o_dest_reg),
        .o_alu_result    (o_alu_result),
        .o_store_data    (o_store_data),
        .o_branch_target (o_branch_target)
    );

    always #(clk_period / 2) i_clock = ~i_clock;

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic fail_run(string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_data(string name, data_t got, data_t expected);
        if (got !== expected) begin
            fail_run($sformatf("mismatch %s: got 0x%h, expected 0x%h (instruction %0d)",
                               name, got, expected, check_seq));
        end
    endtask

    task automatic check_reg(string name, reg_idx_t got, reg_idx_t expected);
        if (got !== expected) begin
            fail_run($sformatf("mismatch %s: got 0x%h, expected 0x%h (instruction %0d)",
                               name, got, expected, check_seq));
        end
    endtask

    task automatic check_pc(string name, pc_t got, pc_t expected);
        if (got !== expected) begin
            fail_run($sformatf("mismatch %s: got 0x%h, expected 0x%h (instruction %0d)",
                               name, got, expected, check_seq));
        end
    endtask

    task automatic check_bit(string name, logic got, logic expected);
        if (got !== expected) begin
            fail_run($sformatf("mismatch %s: got 0x%h, expected 0x%h (instruction %0d)",
                               name, got, expected, check_seq));
        end
    endtask

    // Most picks land on r0..r3 so that dependencies are frequent
    function automatic reg_idx_t pick_reg();
        if (rand_range(4) != 0) begin
            return reg_idx_t'(rand_range(4));
        end
        return reg_idx_t'(rand_range(32));
    endfunction

    function automatic logic [15:0] pick_imm();
        logic [31:0] raw;
        int unsigned sel;
        sel = rand_range(4);
        raw = next_rand();
        case (sel)
            0:       return {12'h000, raw[3:0]};
            1:       return {12'hfff, raw[3:0]};
            default: return raw[15:0];
        endcase
    endfunction

    function automatic data_t make_instr();
        int unsigned kind;
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        logic [15:0] imm;
        funct_e      funct;
        opcode_e     opcode;
        kind = rand_range(11);
        rs   = pick_reg();
        rt   = pick_reg();
        rd   = pick_reg();
        imm  = pick_imm();
        if (kind < 5) begin
            case (kind)
                0:       funct = F_ADD;
                1:       funct = F_SUB;
                2:       funct = F_AND;
                3:       funct = F_OR;
                default: funct = F_SLT;
            endcase
            return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
        end
        case (kind)
            5:       opcode = OP_ADDI;
            6:       opcode = OP_SLTI;
            7:       opcode = OP_ANDI;
            8:       opcode = OP_ORI;
            9:       opcode = OP_BEQ;
            default: opcode = OP_SW;
        endcase
        return {opcode, rs, rt, imm};
    endfunction

    task automatic compare_outputs();
        expect_t exp;
        if (exp_q.size() == 0) begin
            fail_run("o_valid went high with no instruction outstanding");
        end else begin
            exp       = exp_q.pop_front();
            check_seq = exp.seq;
            if (cycle_count != exp.cycle) begin
                fail_run($sformatf("instruction %0d came out in cycle %0d instead of cycle %0d",
                                   exp.seq, cycle_count, exp.cycle));
            end
            check_bit("o_reg_write", o_reg_write, exp.reg_write);
            check_bit("o_mem_write", o_mem_write, exp.mem_write);
            check_bit("o_branch_taken", o_branch_taken, exp.branch_taken);
            check_reg("o_dest_reg", o_dest_reg, exp.dest_reg);
            if (exp.opcode == OP_BEQ) begin
                check_pc("o_branch_target", o_branch_target, exp.branch_target);
            end else begin
                check_data("o_alu_result", o_alu_result, exp.alu_result);
            end
            if (exp.opcode == OP_SW) begin
                check_data("o_store_data", o_store_data, exp.store_data);
            end
        end
    endtask

    // Outputs settle after the rising edge, so they are looked at on the falling one
    always @(negedge i_clock) begin
        if (o_valid === 1'b1) begin
            compare_outputs();
        end
    end

    initial begin
        #(time_limit);
        fail_run("watchdog expired before all instructions came out");
    end

    initial begin
        expect_t     exp;
        data_t       instr;
        pc_t         pc;
        int unsigned gap;
        i_clock   = 1'b0;
        i_rst     = 1'b1;
        i_valid   = 1'b0;
        i_instr   = '0;
        i_pc      = '0;
        pc        = '0;
        rng_state = seed;
        model_reset();
        repeat (16) @(posedge i_clock);
        #2;
        i_rst = 1'b0;
        for (int n = 0; n < num_instr; n++) begin
            @(posedge i_clock);
            #2;
            instr     = make_instr();
            exp       = model_execute(instr, pc);
            exp.seq   = n;
            exp.cycle = cycle_count + 2;  // Fixed two-cycle latency
            exp_q.push_back(exp);
            i_valid = 1'b1;
            i_instr = instr;
            i_pc    = pc;
            pc      = pc + 8'd4;
            gap     = rand_range(3);
            repeat (gap) begin
                @(posedge i_clock);
                #2;
                i_valid = 1'b0;
            end
        end
        @(posedge i_clock);
        #2;
        i_valid = 1'b0;
        repeat (4) @(posedge i_clock);
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d instructions never came out", exp_q.size()));
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

/* flist.f */
+incdir+verilog
+incdir+tb
verilog/mips_pkg.sv
verilog/alu.sv
verilog/main_control.sv
verilog/register_file.sv
verilog/ex_stage.sv
verilog/mips_exec_top.sv
tb/tb_mips_exec.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_mips_exec
FLIST      := flist.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
